// ==== verilog/elevator_consts.svh ====
`ifndef ELEVATOR_CONSTS_SVH
`define ELEVATOR_CONSTS_SVH

////////////////////
// Building size
////////////////////

// Floors served by the car, floor 1 is encoded as 0
`define FLOOR_COUNT 11

// Enough bits to hold floor numbers 0 to 10
`define FLOOR_WIDTH 4

////////////////////
// Request queue
////////////////////

// Entries held between a press and its service
`define QUEUE_DEPTH 8

// Read and write pointers wrap on their own at this width
`define QUEUE_PTR_WIDTH 3

`endif

// ==== verilog/elevator_pkg.sv ====
`default_nettype none

`include "elevator_consts.svh"

package elevator_pkg;

    // Floor number, floor 1 is 0 and floor 11 is 10
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, shared by buttons and lights
    typedef logic [`FLOOR_COUNT-1:0] button_vec_t;

    // Queue occupancy, one bit wider than a pointer so a full queue fits
    typedef logic [`QUEUE_PTR_WIDTH:0] queue_count_t;

    // Dispatch FSM
    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_SEND,
        DISP_TRAVEL
    } dispatch_state_t;

endpackage

`default_nettype wire

// ==== verilog/button_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module button_latch (
    input  wire                       clock,
    input  wire                       reset_n,
    input  elevator_pkg::button_vec_t floor_call_buttons,
    input  elevator_pkg::button_vec_t panel_buttons,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  elevator_pkg::floor_t      current_floor,
    input  wire                       full,
    input  wire                       served,
    input  elevator_pkg::floor_t      served_floor,
    output elevator_pkg::button_vec_t call_button_lights,
    output elevator_pkg::button_vec_t panel_button_lights,
    output logic                      push,
    output elevator_pkg::floor_t      push_floor
);

    logic                      service_en;
    logic                      panel_hit;
    logic                      call_hit;
    elevator_pkg::floor_t      panel_floor;
    elevator_pkg::floor_t      call_floor;
    elevator_pkg::button_vec_t set_mask;
    elevator_pkg::button_vec_t clear_mask;

    assign service_en = power_switch && !emergency_btn;

    ////////////////////
    // Request selection
    ////////////////////

    // Walk from the top floor down so the lowest pending press is the one kept
    always_comb begin
        panel_hit   = 1'b0;
        call_hit    = 1'b0;
        panel_floor = '0;
        call_floor  = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (panel_buttons[i] && !panel_button_lights[i] &&
                current_floor != elevator_pkg::floor_t'(i)) begin
                panel_hit   = 1'b1;
                panel_floor = elevator_pkg::floor_t'(i);
            end
            if (floor_call_buttons[i] && !call_button_lights[i] &&
                current_floor != elevator_pkg::floor_t'(i)) begin
                call_hit   = 1'b1;
                call_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    // Car panel beats hall calls; a full queue holds every press back
    assign push       = service_en && !full && (panel_hit || call_hit);
    assign push_floor = panel_hit ? panel_floor : call_floor;

    assign set_mask   = elevator_pkg::button_vec_t'(1) << push_floor;
    assign clear_mask = served ? (elevator_pkg::button_vec_t'(1) << served_floor) : '0;

    ////////////////////
    // Lights
    ////////////////////

    // A serve on the same floor wins over a new set
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            if (push && panel_hit)
                panel_button_lights <= (panel_button_lights | set_mask) & ~clear_mask;
            else
                panel_button_lights <= panel_button_lights & ~clear_mask;
            if (push && !panel_hit)
                call_button_lights <= (call_button_lights | set_mask) & ~clear_mask;
            else
                call_button_lights <= call_button_lights & ~clear_mask;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/request_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "elevator_consts.svh"

module request_queue (
    input  wire                  clock,
    input  wire                  reset_n,
    input  wire                  push,
    input  elevator_pkg::floor_t push_floor,
    input  wire                  pop,
    output elevator_pkg::floor_t head_floor,
    output logic                 not_empty,
    output logic                 full
);

    elevator_pkg::floor_t        entries [`QUEUE_DEPTH];
    logic [`QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [`QUEUE_PTR_WIDTH-1:0] rd_ptr;
    elevator_pkg::queue_count_t  count;
    logic                        do_push;
    logic                        do_pop;

    // Guard against writes past the end and reads from an empty store
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    assign not_empty  = (count != '0);
    assign full       = (count == elevator_pkg::queue_count_t'(`QUEUE_DEPTH));
    assign head_floor = entries[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_push)
            entries[wr_ptr] <= push_floor;
    end

    ////////////////////
    // Pointers
    ////////////////////

    // Depth is a power of two, so the pointers wrap by overflow
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/car_command.sv ====
`timescale 1ns/1ns
`default_nettype none

module car_command (
    input  wire                  clock,
    input  wire                  reset_n,
    input  wire                  power_switch,
    input  wire                  emergency_btn,
    input  wire                  door_open_btn,
    input  wire                  door_close_btn,
    input  elevator_pkg::floor_t current_floor,
    input  wire                  elevator_moving,
    input  elevator_pkg::floor_t head_floor,
    input  wire                  not_empty,
    output logic                 pop,
    output logic                 served,
    output elevator_pkg::floor_t served_floor,
    output elevator_pkg::floor_t elevator_floor_selector,
    output logic                 direction_selector,
    output logic                 activate_elevator,
    output logic                 door_open_allowed,
    output logic                 door_close_allowed
);

    elevator_pkg::dispatch_state_t state;
    logic                          service_en;
    logic                          car_stopped;

    assign service_en  = power_switch && !emergency_btn;
    assign car_stopped = !elevator_moving;

    ////////////////////
    // Dispatch FSM
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                   <= elevator_pkg::DISP_IDLE;
            pop                     <= 1'b0;
            served                  <= 1'b0;
            served_floor            <= '0;
            elevator_floor_selector <= '0;
            direction_selector      <= 1'b0;
            activate_elevator       <= 1'b0;
        end else begin
            pop    <= 1'b0;
            served <= 1'b0;
            if (!service_en) begin
                // Queue stays intact, the head is dispatched again on recovery
                state             <= elevator_pkg::DISP_IDLE;
                activate_elevator <= 1'b0;
            end else begin
                case (state)
                    elevator_pkg::DISP_IDLE: begin
                        // Skip the cycle where the previous head is still leaving
                        if (car_stopped && not_empty && !pop) begin
                            if (head_floor == current_floor) begin
                                pop          <= 1'b1;
                                served       <= 1'b1;
                                served_floor <= head_floor;
                            end else begin
                                elevator_floor_selector <= head_floor;
                                direction_selector      <= (head_floor > current_floor);
                                activate_elevator       <= 1'b1;
                                state                   <= elevator_pkg::DISP_SEND;
                            end
                        end
                    end
                    elevator_pkg::DISP_SEND: begin
                        if (elevator_moving) begin
                            activate_elevator <= 1'b0;
                            state             <= elevator_pkg::DISP_TRAVEL;
                        end
                    end
                    elevator_pkg::DISP_TRAVEL: begin
                        if (car_stopped && current_floor == elevator_floor_selector) begin
                            pop          <= 1'b1;
                            served       <= 1'b1;
                            served_floor <= elevator_floor_selector;
                            state        <= elevator_pkg::DISP_IDLE;
                        end
                    end
                    default: state <= elevator_pkg::DISP_IDLE;
                endcase
            end
        end
    end

    // Doors only respond with the car at rest and power on
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && car_stopped && power_switch;
            door_close_allowed <= door_close_btn && car_stopped && power_switch;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/elevator_controller_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module elevator_controller_top (
    input  wire                       clock,
    input  wire                       reset_n,
    input  elevator_pkg::button_vec_t floor_call_buttons,
    input  elevator_pkg::button_vec_t panel_buttons,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    input  wire                       emergency_btn,
    input  wire                       power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  wire                       elevator_moving,
    output elevator_pkg::floor_t      elevator_floor_selector,
    output wire                       direction_selector,
    output wire                       activate_elevator,
    output elevator_pkg::button_vec_t call_button_lights,
    output elevator_pkg::button_vec_t panel_button_lights,
    output wire                       door_open_allowed,
    output wire                       door_close_allowed
);

    // Input side to queue
    wire                  push;
    elevator_pkg::floor_t push_floor;
    wire                  full;

    // Queue to output side
    elevator_pkg::floor_t head_floor;
    wire                  not_empty;
    wire                  pop;

    // Output side back to the lights
    wire                  served;
    elevator_pkg::floor_t served_floor;

    button_latch u_button_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .current_floor       (current_floor),
        .full                (full),
        .served              (served),
        .served_floor        (served_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push                (push),
        .push_floor          (push_floor)
    );

    request_queue u_request_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (push),
        .push_floor (push_floor),
        .pop        (pop),
        .head_floor (head_floor),
        .not_empty  (not_empty),
        .full       (full)
    );

    car_command u_car_command (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .head_floor              (head_floor),
        .not_empty               (not_empty),
        .pop                     (pop),
        .served                  (served),
        .served_floor            (served_floor),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== verification/elevator_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module elevator_checker (
    input  wire                       clock,
    input  wire                       exp_en,
    input  wire [6:0]                 exp_mask,
    input  wire                       exp_act,
    input  elevator_pkg::floor_t      exp_sel,
    input  wire                       exp_dir,
    input  elevator_pkg::button_vec_t exp_call,
    input  elevator_pkg::button_vec_t exp_panel,
    input  wire                       exp_dopen,
    input  wire                       exp_dclose,
    input  wire                       activate_elevator,
    input  elevator_pkg::floor_t      elevator_floor_selector,
    input  wire                       direction_selector,
    input  elevator_pkg::button_vec_t call_button_lights,
    input  elevator_pkg::button_vec_t panel_button_lights,
    input  wire                       door_open_allowed,
    input  wire                       door_close_allowed,
    output int                        error_count
);

    task automatic compare_field(input string name, input logic [10:0] got,
                                 input logic [10:0] want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            error_count++;
        end
    endtask

    initial error_count = 0;

    ////////////////////
    // Compare
    ////////////////////

    // DUT outputs move on the rising edge and are settled here
    always @(negedge clock) begin
        if (exp_en) begin
            if (exp_mask[0])
                compare_field("activate_elevator", activate_elevator, exp_act);
            if (exp_mask[1])
                compare_field("elevator_floor_selector", elevator_floor_selector, exp_sel);
            if (exp_mask[2])
                compare_field("direction_selector", direction_selector, exp_dir);
            if (exp_mask[3])
                compare_field("call_button_lights", call_button_lights, exp_call);
            if (exp_mask[4])
                compare_field("panel_button_lights", panel_button_lights, exp_panel);
            if (exp_mask[5])
                compare_field("door_open_allowed", door_open_allowed, exp_dopen);
            if (exp_mask[6])
                compare_field("door_close_allowed", door_close_allowed, exp_dclose);
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_elevator.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_elevator;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::button_vec_t floor_call_buttons;
    elevator_pkg::button_vec_t panel_buttons;
    logic                      door_open_btn;
    logic                      door_close_btn;
    logic                      emergency_btn;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor;
    logic                      elevator_moving;
    elevator_pkg::floor_t      elevator_floor_selector;
    wire                       direction_selector;
    wire                       activate_elevator;
    elevator_pkg::button_vec_t call_button_lights;
    elevator_pkg::button_vec_t panel_button_lights;
    wire                       door_open_allowed;
    wire                       door_close_allowed;

    // Expected values handed to the checker one record at a time
    logic                      exp_en;
    logic [6:0]                exp_mask;
    logic                      exp_act;
    elevator_pkg::floor_t      exp_sel;
    logic                      exp_dir;
    elevator_pkg::button_vec_t exp_call;
    elevator_pkg::button_vec_t exp_panel;
    logic                      exp_dopen;
    logic                      exp_dclose;
    wire [31:0]                error_count;

    logic [10:0] field [0:7];
    logic [7:0]  op;
    int          fd;
    int          n;
    int          seed_value;
    int          timeouts;
    int          record_faults;

    elevator_controller_top DUT (.*);

    elevator_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // Record handlers
    ////////////////////

    // Code numbering matches the mask bits of an expect record
    function automatic logic [10:0] output_by_code(input int code);
        logic [10:0] value;
        case (code)
            0: value = activate_elevator;
            1: value = elevator_floor_selector;
            2: value = direction_selector;
            3: value = call_button_lights;
            4: value = panel_button_lights;
            5: value = door_open_allowed;
            6: value = door_close_allowed;
            default: value = 'x;
        endcase
        return value;
    endfunction

    // Output names for timeout reports
    function automatic string output_name(input int code);
        string name;
        case (code)
            0: name = "activate_elevator";
            1: name = "elevator_floor_selector";
            2: name = "direction_selector";
            3: name = "call_button_lights";
            4: name = "panel_button_lights";
            5: name = "door_open_allowed";
            6: name = "door_close_allowed";
            default: name = "an unknown output";
        endcase
        return name;
    endfunction

    task automatic apply_inputs();
        @(posedge clock);
        exp_en             <= 1'b0;
        floor_call_buttons <= field[0];
        panel_buttons      <= field[1];
        door_open_btn      <= field[2][0];
        door_close_btn     <= field[3][0];
        emergency_btn      <= field[4][0];
        power_switch       <= field[5][0];
        current_floor      <= field[6][3:0];
        elevator_moving    <= field[7][0];
    endtask

    task automatic post_expectation();
        @(posedge clock);
        exp_en     <= 1'b1;
        exp_mask   <= field[0][6:0];
        exp_act    <= field[1][0];
        exp_sel    <= field[2][3:0];
        exp_dir    <= field[3][0];
        exp_call   <= field[4];
        exp_panel  <= field[5];
        exp_dopen  <= field[6][0];
        exp_dclose <= field[7][0];
    endtask

    task automatic wait_for_output(input int code, input logic [10:0] value, input int limit);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clock);
        exp_en <= 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clock);
            if (output_by_code(code) === value)
                seen = 1'b1;
            else
                cycles++;
        end
        if (!seen) begin
            $display("Timeout at %0t: %s never reached %h within %0d cycles",
                     $time, output_name(code), value, limit);
            timeouts++;
        end
    endtask

    task automatic idle_gap();
        int cycles;
        cycles = $urandom_range(3, 0);
        @(posedge clock);
        exp_en <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    task automatic skip_comment();
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
    endtask

    task automatic report_bad_record();
        $display("Stimulus record '%c' is unknown or has missing fields", op);
        record_faults++;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed_value         = $urandom(32'h2a3d97ca);
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b0;
        current_floor      = '0;
        elevator_moving    = 1'b0;
        exp_en             = 1'b0;
        exp_mask           = '0;
        timeouts           = 0;
        record_faults      = 0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        fd = $fopen("verification/elevator_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file verification/elevator_stim.txt could not be opened");
            record_faults++;
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                case (op)
                    "#": skip_comment();
                    "D", "E": begin
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h", field[0], field[1],
                                    field[2], field[3], field[4], field[5], field[6], field[7]);
                        if (n != 8)
                            report_bad_record();
                        else if (op == "D")
                            apply_inputs();
                        else
                            post_expectation();
                    end
                    "W": begin
                        n = $fscanf(fd, "%h %h %h", field[0], field[1], field[2]);
                        if (n != 3)
                            report_bad_record();
                        else
                            wait_for_output(field[0], field[1], field[2]);
                    end
                    "G": idle_gap();
                    default: report_bad_record();
                endcase
            end
            $fclose(fd);
        end

        // Last compare lands on the falling edge before this one
        @(posedge clock);
        exp_en <= 1'b0;
        @(negedge clock);
        $display("Run finished with %0d errors, %0d timeouts, %0d stimulus faults",
                 error_count, timeouts, record_faults);
        if (error_count == 0 && timeouts == 0 && record_faults == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/elevator_stim.txt ====
# D call panel dopen dclose emerg power floor moving; E mask act sel dir call panel dopen dclose
# W code value limit; G idle gap; hex, mask bit/code 0..6 = act sel dir call panel dopen dclose
D 000 000 0 0 0 1 2 0
D 000 080 0 0 0 1 2 0
W 0 1 10
E 17 1 7 1 000 080 0 0
D 000 000 0 0 0 1 2 1
W 0 0 10
# Travelling: panel 5 and call 3 together, call 2 is the current floor, doors refused
D 00c 020 1 1 0 1 2 1
E 78 0 0 0 000 0a0 0 0
E 78 0 0 0 008 0a0 0 0
# Arrival at 7 clears its light, then 5 goes out downwards
D 000 000 0 0 0 1 7 0
W 4 020 10
W 0 1 10
E 0f 1 5 0 008 000 0 0
D 000 000 1 0 0 1 7 0
E 60 0 0 0 000 000 1 0
D 000 000 0 1 0 1 7 0
E 60 0 0 0 000 000 0 1
# Emergency, then power off
D 001 400 0 0 1 1 7 0
E 19 0 0 0 008 020 0 0
D 001 400 1 1 0 0 7 0
E 79 0 0 0 008 020 0 0
D 000 000 0 0 0 1 7 0
W 0 1 10
E 07 1 5 0 000 000 0 0
# Queue fills while travelling, panel 8 waits for the stop at 5
D 000 19f 0 0 0 1 6 1
W 4 0bf 20
G
E 10 0 0 0 000 0bf 0 0
D 000 19f 0 0 0 1 5 0
W 4 19f 20
E 1f 1 3 0 008 19f 0 0

// ==== vlog.f ====
+incdir+verilog
verilog/elevator_pkg.sv
verilog/button_latch.sv
verilog/request_queue.sv
verilog/car_command.sv
verilog/elevator_controller_top.sv
verification/elevator_checker.sv
verification/tb_elevator.sv
